// ==== src.f ====
+incdir+.
sort_pkg.sv
merge_link_if.sv
sync_fifo.sv
merge_ctrl.sv
merge_stage.sv
run_splitter.sv
run_collector.sv
merge_sorter_top.sv
merge_sorter_checker.sv
merge_sorter_tb.sv

// ==== merge_sorter_tb.sv ====
`timescale 1ns/1ps
`include "sort_consts.svh"

module merge_sorter_tb import sort_pkg::*; ();

   typedef key_t block_t [`BLOCK];

   localparam int IN_WAIT_MAX    = 500;    // cycles to wait for o_in_full low
   localparam int DRAIN_WAIT_MAX = 4000;   // cycles to wait for all output

   logic        i_clk;
   logic        i_rst;
   key_t        i_key;
   logic        i_key_wr;
   logic        o_in_full;
   logic        i_out_hold;
   key_t        o_key;
   logic        o_key_last;
   logic        o_key_valid;

   key_t        exp_key[$];                // sorted keys still to come out
   logic        exp_last[$];               // matching block end flags
   logic [31:0] key_seed;                  // lcg state for keys
   logic [31:0] hold_seed;                 // lcg state for hold toggling
   logic        hold_rand;                 // randomize i_out_hold when set
   int          errors;
   int          checks;

   wire [`STAGES-1:0] stage_fail;          // assertion flag per merge stage

   merge_sorter_top dut_i (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_key       (i_key),
      .i_key_wr    (i_key_wr),
      .o_in_full   (o_in_full),
      .i_out_hold  (i_out_hold),
      .o_key       (o_key),
      .o_key_last  (o_key_last),
      .o_key_valid (o_key_valid)
   );

   bind merge_stage merge_sorter_checker checker_i (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_state     (ctrl_i.state),
      .i_pop_a     (pop_a),
      .i_pop_b     (pop_b),
      .i_a_empty   (a_empty),
      .i_b_empty   (b_empty),
      .i_a_term    (a_head == '0),
      .i_b_term    (b_head == '0),
      .i_in_wr     (in_link.wr),
      .i_in_full   (in_link.dest ? in_link.full_b : in_link.full_a),
      .i_emit_term (emit_term)
   );

   for (genvar k = 0; k < `STAGES; k++) begin : g_chk
      assign stage_fail[k] = dut_i.g_stage[k].stage_i.checker_i.fail_seen;
   end

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;           // 10 ns period
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model and stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic key_t rand_key(input key_t mask);
      key_t k;
      key_seed = lcg_next(key_seed);
      k = key_seed[31:16] & mask;
      return (k == '0) ? key_t'(1) : k;    // zero is reserved
   endfunction

   // ascending insertion sort of one block
   function automatic void sort_ref(input block_t blk, output block_t res);
      key_t tmp;
      res = blk;
      for (int i = 1; i < `BLOCK; i++) begin
         for (int j = i; j > 0 && res[j-1] > res[j]; j--) begin
            tmp      = res[j];
            res[j]   = res[j-1];
            res[j-1] = tmp;
         end
      end
   endfunction

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("tests failed");
      $finish;
   endtask

   // called right after a falling edge
   task automatic send_key(input key_t k);
      int waited;
      waited = 0;
      while (o_in_full) begin
         @(negedge i_clk);
         waited++;
         if (waited > IN_WAIT_MAX)
            abort_run("timeout: o_in_full stayed high, input is stuck");
      end
      i_key    = k;
      i_key_wr = 1'b1;
      @(negedge i_clk);
      i_key_wr = 1'b0;
      // an accepted key leaves its terminator pending
      if (o_in_full !== 1'b1) begin
         errors++;
         $display("ERR o_in_full got %h expected %h", o_in_full, 1'b1);
      end
   endtask

   task automatic write_block(input block_t blk);
      block_t sorted;
      sort_ref(blk, sorted);
      for (int i = 0; i < `BLOCK; i++) begin
         exp_key.push_back(sorted[i]);
         exp_last.push_back(i == `BLOCK - 1);   // only the eighth key
      end
      for (int i = 0; i < `BLOCK; i++)
         send_key(blk[i]);
   endtask

   task automatic write_random(input int count, input key_t mask);
      block_t blk;
      for (int b = 0; b < count; b++) begin
         for (int i = 0; i < `BLOCK; i++)
            blk[i] = rand_key(mask);
         write_block(blk);
      end
   endtask

   // wait for every expected word, then idle to catch extra output
   task automatic finish_test(input int num, input string name, input int err_start);
      int waited;
      waited = 0;
      while (exp_key.size() != 0) begin
         @(negedge i_clk);
         waited++;
         if (waited > DRAIN_WAIT_MAX)
            abort_run($sformatf("timeout: %0d sorted words never came out",
                                exp_key.size()));
      end
      repeat (30) @(negedge i_clk);
      $display("test %0d %s: %s, %0d errors", num, name,
               (errors == err_start) ? "ok" : "FAIL", errors - err_start);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // comparison process and i_out_hold driver
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      key_t k;
      logic l;
      i_out_hold = 1'b0;
      hold_seed  = 32'h59bd4212;
      forever begin
         @(negedge i_clk);
         if (o_key_valid && i_out_hold) begin
            errors++;
            $display("o_key_valid was high although i_out_hold was high");
         end
         if (o_key_valid) begin
            checks++;
            if (exp_key.size() == 0) begin
               errors++;
               $display("output word %h appeared with nothing expected", o_key);
            end else begin
               k = exp_key.pop_front();
               l = exp_last.pop_front();
               if (o_key !== k) begin
                  errors++;
                  $display("ERR o_key got %h expected %h", o_key, k);
               end
               if (o_key_last !== l) begin
                  errors++;
                  $display("ERR o_key_last got %h expected %h", o_key_last, l);
               end
            end
         end
         hold_seed  = lcg_next(hold_seed);
         i_out_hold = hold_rand & hold_seed[31];   // about half the cycles held
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      block_t blk;
      int     err_start;
      i_rst     = 1'b1;
      i_key     = '0;
      i_key_wr  = 1'b0;
      hold_rand = 1'b0;
      key_seed  = 32'h59bd4212;
      errors    = 0;
      checks    = 0;
      repeat (2) @(negedge i_clk);         // two reset cycles
      i_rst = 1'b0;

      err_start = errors;
      write_random(1, '1);
      finish_test(1, "single block", err_start);

      err_start = errors;
      write_random(10, '1);
      finish_test(2, "ten blocks back to back", err_start);

      err_start = errors;
      write_random(3, key_t'(3));          // keys 1..3 with many copies
      blk = '{default: key_t'(16'h0042)};
      write_block(blk);
      finish_test(3, "duplicate keys", err_start);

      err_start = errors;
      blk = '{16'd10, 16'd20, 16'd30, 16'd40, 16'd50, 16'd60, 16'd70, 16'd80};
      write_block(blk);
      blk = '{16'd80, 16'd70, 16'd60, 16'd50, 16'd40, 16'd30, 16'd20, 16'd10};
      write_block(blk);
      blk = '{16'hFFFF, 16'h0001, 16'h8000, 16'h0001,
              16'hFFFF, 16'h7FFF, 16'h0002, 16'hFFFE};
      write_block(blk);
      finish_test(4, "sorted, reversed and extreme keys", err_start);

      err_start = errors;
      hold_rand = 1'b1;
      write_random(20, '1);
      finish_test(5, "random output hold", err_start);
      hold_rand = 1'b0;

      err_start = errors;
      send_key(rand_key('1));              // partial block that is never completed
      send_key(rand_key('1));
      send_key(rand_key('1));
      i_rst = 1'b1;
      repeat (2) @(negedge i_clk);
      i_rst = 1'b0;
      repeat (40) @(negedge i_clk);        // o_key_valid must stay low here
      write_random(1, '1);
      finish_test(6, "reset in mid block", err_start);

      if (stage_fail != '0)
         $display("merge stage assertions fired in stages %b", stage_fail);
      $display("%0d words checked, %0d errors", checks, errors);
      if (errors == 0 && stage_fail == '0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== merge_sorter_checker.sv ====
`timescale 1ns/1ps

module merge_sorter_checker import sort_pkg::*; (
   input logic         i_clk,
   input logic         i_rst,
   input merge_state_t i_state,            // controller state register
   input logic         i_pop_a,
   input logic         i_pop_b,
   input logic         i_a_empty,
   input logic         i_b_empty,
   input logic         i_a_term,           // head of fifo a is zero
   input logic         i_b_term,           // head of fifo b is zero
   input logic         i_in_wr,            // input link write strobe
   input logic         i_in_full,          // full level of the fifo the link selects
   input logic         i_emit_term         // controller closes a run
);

   logic fail_seen = 1'b0;                 // set once any rule below breaks

   ////////////////////////////////////////////////////////////////////////////
   // merge stage rules
   ////////////////////////////////////////////////////////////////////////////

   a_state_legal: assert property (@(posedge i_clk) disable iff (i_rst)
      i_state inside {MERGE, DRAIN_A, DRAIN_B, TERM})
      else begin
         $error("merge controller state out of range");
         fail_seen = 1'b1;
      end

   a_pop_a_nonempty: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_pop_a && i_a_empty))
      else begin
         $error("fifo a popped while empty");
         fail_seen = 1'b1;
      end

   a_pop_b_nonempty: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_pop_b && i_b_empty))
      else begin
         $error("fifo b popped while empty");
         fail_seen = 1'b1;
      end

   // a word may only arrive when its target fifo has room
   a_wr_not_full: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_in_wr && i_in_full))
      else begin
         $error("input link written into a full fifo");
         fail_seen = 1'b1;
      end

   // closing a run drops the terminators at both heads
   a_term_in_term: assert property (@(posedge i_clk) disable iff (i_rst)
      i_emit_term |-> (i_state == TERM && i_a_term && i_b_term))
      else begin
         $error("terminator emitted outside TERM or without two input terminators");
         fail_seen = 1'b1;
      end

endmodule

// ==== merge_sorter_top.sv ====
`timescale 1ns/1ps
`include "sort_consts.svh"

module merge_sorter_top import sort_pkg::*; (
   input  logic i_clk,
   input  logic i_rst,
   input  key_t i_key,                     // nonzero key
   input  logic i_key_wr,                  // key write strobe
   output logic o_in_full,                 // input back-pressure level
   input  logic i_out_hold,                // consumer hold level
   output key_t o_key,                     // sorted key
   output logic o_key_last,                // block end marker
   output logic o_key_valid                // output strobe
);

   // link[0] feeds stage 0, link[STAGES] feeds the collector
   merge_link_if link [0:`STAGES] ();

   run_splitter splitter_i (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_key     (i_key),
      .i_key_wr  (i_key_wr),
      .o_in_full (o_in_full),
      .out_link  (link[0])
   );

   ////////////////////////////////////////////////////////////////////////////
   // merge network
   ////////////////////////////////////////////////////////////////////////////

   for (genvar k = 0; k < `STAGES; k++) begin : g_stage
      merge_stage stage_i (
         .i_clk    (i_clk),
         .i_rst    (i_rst),
         .in_link  (link[k]),              // runs of 2**k keys
         .out_link (link[k+1])             // runs of 2**(k+1) keys
      );
   end

   run_collector collector_i (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .in_link     (link[`STAGES]),
      .i_out_hold  (i_out_hold),
      .o_key       (o_key),
      .o_key_last  (o_key_last),
      .o_key_valid (o_key_valid)
   );

endmodule

// ==== run_collector.sv ====
`timescale 1ns/1ps
`include "sort_consts.svh"

module run_collector import sort_pkg::*; (
   input  logic      i_clk,
   input  logic      i_rst,
   merge_link_if.dst in_link,              // full-block runs from last stage
   input  logic      i_out_hold,           // consumer hold level
   output key_t      o_key,
   output logic      o_key_last,           // final key of a block
   output logic      o_key_valid           // output strobe
);

   key_t      held_key;                    // waits for the following word
   logic      held_vld;
   logic      in_term;                     // incoming word closes the run
   logic      push;
   logic      pop;
   logic      fifo_empty;
   logic      fifo_full;
   out_word_t push_word;
   out_word_t head_word;

   assign in_term   = (in_link.data == '0);
   assign push      = in_link.wr & held_vld;
   assign push_word = '{key: held_key, last: in_term};
   assign pop       = ~i_out_hold & ~fifo_empty;

   // one level for both destinations, runs are not split here
   assign in_link.full_a = fifo_full;
   assign in_link.full_b = fifo_full;

   sync_fifo #(.T(out_word_t), .DEPTH(`FIFO_DEPTH)) out_fifo_i (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_wr    (push),
      .i_data  (push_word),
      .i_rd    (pop),
      .o_data  (head_word),
      .o_empty (fifo_empty),
      .o_full  (fifo_full)
   );

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         held_vld    <= 1'b0;
         o_key_valid <= 1'b0;
      end else begin
         if (in_link.wr)
            held_vld <= ~in_term;          // terminator empties the holder
         o_key_valid <= pop;
      end
   end

   always_ff @(posedge i_clk) begin
      if (in_link.wr && !in_term)
         held_key <= in_link.data;
      if (pop) begin
         o_key      <= head_word.key;
         o_key_last <= head_word.last;
      end
   end

endmodule

// ==== run_splitter.sv ====
`timescale 1ns/1ps

module run_splitter import sort_pkg::*; (
   input  logic      i_clk,
   input  logic      i_rst,
   input  key_t      i_key,                // host key, never zero
   input  logic      i_key_wr,             // host write strobe
   output logic      o_in_full,            // host holds off while high
   merge_link_if.src out_link              // one-key runs to stage 0
);

   key_t key_q;                            // accepted key
   logic key_vld;                          // key goes out this cycle
   logic term_pend;                        // terminator still owed
   logic dest_q;                           // fifo for the current run
   logic dest_full;
   logic accept;
   logic term_go;

   assign dest_full = dest_q ? out_link.full_b : out_link.full_a;
   assign o_in_full = term_pend | dest_full;
   assign accept    = i_key_wr & ~o_in_full;
   assign term_go   = term_pend & ~key_vld & ~dest_full;

   // key leaves the cycle after accept, its terminator once room is seen
   assign out_link.wr   = key_vld | term_go;
   assign out_link.data = key_vld ? key_q : '0;
   assign out_link.dest = dest_q;

   ////////////////////////////////////////////////////////////////////////////
   // run sequencing
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         key_vld   <= 1'b0;
         term_pend <= 1'b0;
         dest_q    <= 1'b0;                // start dealing to fifo a
      end else begin
         key_vld <= accept;
         if (accept)
            term_pend <= 1'b1;
         else if (term_go)
            term_pend <= 1'b0;
         if (term_go)
            dest_q <= ~dest_q;             // next run to the other fifo
      end
   end

   always_ff @(posedge i_clk) begin
      if (accept)
         key_q <= i_key;
   end

endmodule

// ==== merge_stage.sv ====
`timescale 1ns/1ps
`include "sort_consts.svh"

module merge_stage import sort_pkg::*; (
   input  logic      i_clk,
   input  logic      i_rst,
   merge_link_if.dst in_link,              // runs from the previous level
   merge_link_if.src out_link              // doubled runs to the next level
);

   key_t a_head;
   key_t b_head;
   logic a_empty;
   logic b_empty;
   logic pop_a;
   logic pop_b;
   logic select_a;
   logic emit;
   logic emit_term;
   logic dest;
   logic out_vld;                          // output register holds a word
   key_t out_data;
   logic out_dest;
   logic dest_full;                        // full level at the word's target

   sync_fifo #(.T(key_t), .DEPTH(`FIFO_DEPTH)) fifo_a_i (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_wr    (in_link.wr & ~in_link.dest),
      .i_data  (in_link.data),
      .i_rd    (pop_a),
      .o_data  (a_head),
      .o_empty (a_empty),
      .o_full  (in_link.full_a)
   );

   sync_fifo #(.T(key_t), .DEPTH(`FIFO_DEPTH)) fifo_b_i (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_wr    (in_link.wr & in_link.dest),
      .i_data  (in_link.data),
      .i_rd    (pop_b),
      .o_data  (b_head),
      .o_empty (b_empty),
      .o_full  (in_link.full_b)
   );

   merge_ctrl ctrl_i (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_a_empty   (a_empty),
      .i_b_empty   (b_empty),
      .i_a_term    (a_head == '0),
      .i_b_term    (b_head == '0),
      .i_a_lte_b   (a_head <= b_head),
      .i_out_full  (out_vld & dest_full),  // busy only if the word cannot leave
      .o_pop_a     (pop_a),
      .o_pop_b     (pop_b),
      .o_select_a  (select_a),
      .o_emit      (emit),
      .o_emit_term (emit_term),
      .o_dest      (dest)
   );

   ////////////////////////////////////////////////////////////////////////////
   // output register
   ////////////////////////////////////////////////////////////////////////////

   assign dest_full = out_dest ? out_link.full_b : out_link.full_a;

   always_ff @(posedge i_clk) begin
      if (i_rst)
         out_vld <= 1'b0;
      else if (emit)
         out_vld <= 1'b1;                  // refilled while draining
      else if (out_link.wr)
         out_vld <= 1'b0;
   end

   always_ff @(posedge i_clk) begin
      if (emit) begin
         out_data <= emit_term ? '0 : (select_a ? a_head : b_head);
         out_dest <= dest;                 // terminator keeps its run's target
      end
   end

   assign out_link.wr   = out_vld & ~dest_full;
   assign out_link.data = out_data;
   assign out_link.dest = out_dest;

endmodule

// ==== merge_ctrl.sv ====
`timescale 1ns/1ps

module merge_ctrl import sort_pkg::*; (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_a_empty,                 // fifo a has no head
   input  logic i_b_empty,                 // fifo b has no head
   input  logic i_a_term,                  // head of a is a terminator
   input  logic i_b_term,                  // head of b is a terminator
   input  logic i_a_lte_b,                 // head a <= head b
   input  logic i_out_full,                // output register cannot take a word
   output logic o_pop_a,                   // read fifo a
   output logic o_pop_b,                   // read fifo b
   output logic o_select_a,                // output mux picks head a
   output logic o_emit,                    // load output register
   output logic o_emit_term,               // load a terminator
   output logic o_dest                     // next stage fifo for this run
);

   merge_state_t state;
   merge_state_t state_nxt;
   logic         need_a;                   // state looks at head a
   logic         need_b;                   // state looks at head b
   logic         stall;
   logic         dest_q;

   assign need_a = (state != DRAIN_B);
   assign need_b = (state != DRAIN_A);
   assign stall  = i_out_full | (need_a & i_a_empty) | (need_b & i_b_empty);
   assign o_dest = dest_q;

   ////////////////////////////////////////////////////////////////////////////
   // next state and strobes
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_nxt   = state;
      o_pop_a     = 1'b0;
      o_pop_b     = 1'b0;
      o_select_a  = 1'b1;
      o_emit      = 1'b0;
      o_emit_term = 1'b0;
      if (!stall) begin
         case (state)
            MERGE: begin
               if (i_a_term && i_b_term) begin
                  state_nxt = TERM;            // two empty runs
               end else if (i_a_term) begin
                  state_nxt = DRAIN_B;         // a exhausted first
               end else if (i_b_term) begin
                  state_nxt = DRAIN_A;         // b exhausted first
               end else begin
                  o_select_a = i_a_lte_b;      // ties go to a
                  o_pop_a    = i_a_lte_b;
                  o_pop_b    = ~i_a_lte_b;
                  o_emit     = 1'b1;
               end
            end
            DRAIN_A: begin
               if (i_a_term) begin
                  state_nxt = TERM;
               end else begin
                  o_pop_a = 1'b1;              // copy a through
                  o_emit  = 1'b1;
               end
            end
            DRAIN_B: begin
               if (i_b_term) begin
                  state_nxt = TERM;
               end else begin
                  o_select_a = 1'b0;
                  o_pop_b    = 1'b1;           // copy b through
                  o_emit     = 1'b1;
               end
            end
            TERM: begin
               // drop both input terminators and close the merged run
               o_pop_a     = 1'b1;
               o_pop_b     = 1'b1;
               o_emit      = 1'b1;
               o_emit_term = 1'b1;
               state_nxt   = MERGE;
            end
            default: state_nxt = MERGE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // state and destination registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state  <= MERGE;
         dest_q <= 1'b0;                   // first run goes to fifo a
      end else begin
         state <= state_nxt;
         if (o_emit_term)
            dest_q <= ~dest_q;             // alternate runs after each close
      end
   end

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/1ps
`include "sort_consts.svh"

module sync_fifo import sort_pkg::*; #(
   parameter type T     = key_t,           // payload type
   parameter int  DEPTH = `FIFO_DEPTH      // number of entries
) (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_wr,                      // push strobe, dropped when full
   input  T     i_data,
   input  logic i_rd,                      // pop strobe, dropped when empty
   output T     o_data,                    // head word, valid while not empty
   output logic o_empty,
   output logic o_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T                 mem [DEPTH];          // circular storage
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;                // words held
   logic             do_wr;
   logic             do_rd;

   assign do_wr   = i_wr & ~o_full;
   assign do_rd   = i_rd & ~o_empty;
   assign o_empty = (count == '0);
   assign o_full  = (count == CNT_W'(DEPTH));
   assign o_data  = mem[rd_ptr];           // head shown without a read

   ////////////////////////////////////////////////////////////////////////////
   // pointers and level
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;    // push only
            2'b01:   count <= count - 1'b1;    // pop only
            default: count <= count;           // both or neither
         endcase
      end
   end

   // storage array
   always_ff @(posedge i_clk) begin
      if (do_wr)
         mem[wr_ptr] <= i_data;
   end

endmodule

// ==== merge_link_if.sv ====
`timescale 1ns/1ps

interface merge_link_if import sort_pkg::*; ();

   logic wr;        // write strobe, one word per cycle
   key_t data;      // key or terminator
   logic dest;      // 0 selects fifo a, 1 selects fifo b
   logic full_a;    // receiver fifo a full level
   logic full_b;    // receiver fifo b full level

   // sending side of a link
   modport src (
      output wr,
      output data,
      output dest,
      input  full_a,
      input  full_b
   );

   // receiving side of a link
   modport dst (
      input  wr,
      input  data,
      input  dest,
      output full_a,
      output full_b
   );

endinterface

// ==== sort_pkg.sv ====
`include "sort_consts.svh"

package sort_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // stream types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [`KEY_W-1:0] key_t;       // unsigned key, 0 marks end of run

   typedef struct packed {
      key_t key;                           // sorted key
      logic last;                          // high on the final key of a block
   } out_word_t;

   ////////////////////////////////////////////////////////////////////////////
   // merge controller states
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      MERGE   = 2'd0,                      // compare both heads
      DRAIN_A = 2'd1,                      // b run done, copy rest of a
      DRAIN_B = 2'd2,                      // a run done, copy rest of b
      TERM    = 2'd3                       // both runs done, close output run
   } merge_state_t;

endpackage

// ==== sort_consts.svh ====
`ifndef SORT_CONSTS_SVH
`define SORT_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// sorter sizing
////////////////////////////////////////////////////////////////////////////

`define KEY_W       16   // key width, zero is the run terminator

`define STAGES      3    // merge levels, each doubles the run length

`define BLOCK       8    // keys per host block, 2**STAGES

// two last-stage runs of BLOCK/2 keys plus their terminators fit here
`define FIFO_DEPTH  16

`endif
